//--- Makefile
# Verilator build and run of the fetch unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module fetch_unit_tb -o sim_fetch_unit
	./obj_dir/sim_fetch_unit > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- design/fetch_pkg.sv
// Types shared by the fetch unit; all addresses are byte addresses with 32-bit words only
package fetch_pkg;

    // Byte address into instruction memory
    typedef logic [31:0] addr_t;

    // Raw 32-bit instruction word
    typedef logic [31:0] instr_t;

    // One instruction per fetch without compressed support
    localparam addr_t PC_STEP = 32'd4;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // Request toward instruction memory
    // Accepted at a rising edge with en high and busy low
    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_req_t;

    // Redirect strobes from execute and privilege stages
    // ctx_switch wins when both strobes are set
    typedef struct packed {
        logic  jump;
        logic  ctx_switch;
        addr_t jump_target;
        addr_t ctx_target;
    } jump_req_t;

    // Entry held in the instruction queue
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_entry_t;

    // Registered instruction handed to decode
    // Same layout as the queue entry, kept as a separate type
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } issue_t;

endpackage

//--- design/fetch_request.sv
// Memory must answer an accepted request in the very next cycle; targets are forced word-aligned
`timescale 1ns/1ps

module fetch_request #(
    parameter fetch_pkg::addr_t START_ADDRESS = 32'h0000_0000,
    parameter int               IQUEUE_SIZE   = 2
) (
    input  logic                               clk,
    input  logic                               reset_n,

    // Redirect from execute and privilege stages
    input  fetch_pkg::jump_req_t               jump_i,

    // Instruction memory
    input  logic                               busy_i,
    input  fetch_pkg::instr_t                  mem_data_i,
    output fetch_pkg::mem_req_t                mem_req_o,

    // Queue side
    input  logic [$clog2(IQUEUE_SIZE+1)-1:0]   queue_count_i,
    output logic                               push_o,
    output fetch_pkg::fetch_entry_t            push_entry_o,
    output logic                               flush_o
);

    localparam int CNT_W = $clog2(IQUEUE_SIZE + 1);

    // Credit limit one bit wider than the count so the sum fits
    localparam logic [CNT_W:0] CREDITS = (CNT_W + 1)'(IQUEUE_SIZE);

    fetch_pkg::addr_t fetch_pc_q;
    fetch_pkg::addr_t tag_pc_q;
    fetch_pkg::addr_t target_pc;
    logic             inflight_q;
    logic             redirect;
    logic             accept;
    logic [CNT_W:0]   credits_used;
    logic             credit_ok;

    // Either strobe redirects the stream
    assign redirect = jump_i.jump | jump_i.ctx_switch;

    // Context switch has priority over a plain jump
    always_comb begin
        if (jump_i.ctx_switch) begin
            target_pc = jump_i.ctx_target;
        end else begin
            target_pc = jump_i.jump_target;
        end
        // Word-aligned fetch only
        target_pc[1:0] = 2'b00;
    end

    // Entries in the queue plus the one word on the bus
    // Count already excludes an entry popped at this edge
    assign credits_used = {1'b0, queue_count_i} + (CNT_W + 1)'(inflight_q);
    assign credit_ok    = credits_used < CREDITS;

    // Request whenever a queue slot is guaranteed and reset is released
    assign mem_req_o.en   = credit_ok & reset_n;
    assign mem_req_o.addr = fetch_pc_q;

    // Handshake with the memory
    assign accept = mem_req_o.en & ~busy_i;

    // Fetch address
    // Stalled requests keep the address and retry
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_pc_q <= START_ADDRESS;
        end else if (redirect) begin
            fetch_pc_q <= target_pc;
        end else if (accept) begin
            fetch_pc_q <= fetch_pc_q + fetch_pkg::PC_STEP;
        end
    end

    // Response expected next cycle
    // A request accepted at the redirect edge is dropped here
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= accept & ~redirect;
        end
    end

    // Address of the word now on the bus
    always_ff @(posedge clk) begin
        if (accept) begin
            tag_pc_q <= fetch_pc_q;
        end
    end

    // Push lands one cycle after acceptance
    assign push_o             = inflight_q;
    assign push_entry_o.pc    = tag_pc_q;
    assign push_entry_o.instr = mem_data_i;

    // Same strobe empties the queue and the issue slot
    assign flush_o = redirect;

endmodule

//--- design/fetch_unit.sv
// Single outstanding memory request with a fixed one-cycle response; redirect strobes last one cycle
`timescale 1ns/1ps

module fetch_unit #(
    parameter fetch_pkg::addr_t START_ADDRESS = 32'h0000_0000,
    parameter int               IQUEUE_SIZE   = 2
) (
    input  logic                 clk,
    input  logic                 reset_n,

    // Decode side
    input  logic                 enable_i,
    output fetch_pkg::issue_t    issue_o,
    output logic                 valid_o,
    output logic                 jumping_o,

    // Redirect
    input  fetch_pkg::jump_req_t jump_i,

    // Instruction memory
    input  logic                 busy_i,
    input  fetch_pkg::instr_t    mem_data_i,
    output fetch_pkg::mem_req_t  mem_req_o
);

    localparam int CNT_W = $clog2(IQUEUE_SIZE + 1);

    // Request to queue
    logic                    push;
    fetch_pkg::fetch_entry_t push_entry;
    logic                    flush;

    // Queue to issue and back to request
    fetch_pkg::fetch_entry_t head_entry;
    logic                    not_empty;
    logic [CNT_W-1:0]        count;
    logic                    pop;

    fetch_request #(
        .START_ADDRESS (START_ADDRESS),
        .IQUEUE_SIZE   (IQUEUE_SIZE)
    ) u_fetch_request (
        .clk           (clk),
        .reset_n       (reset_n),
        .jump_i        (jump_i),
        .busy_i        (busy_i),
        .mem_data_i    (mem_data_i),
        .mem_req_o     (mem_req_o),
        .queue_count_i (count),
        .push_o        (push),
        .push_entry_o  (push_entry),
        .flush_o       (flush)
    );

    instr_queue #(
        .IQUEUE_SIZE  (IQUEUE_SIZE)
    ) u_instr_queue (
        .clk          (clk),
        .reset_n      (reset_n),
        .flush_i      (flush),
        .push_i       (push),
        .push_entry_i (push_entry),
        .pop_i        (pop),
        .head_entry_o (head_entry),
        .not_empty_o  (not_empty),
        .count_o      (count)
    );

    issue_stage #(
        .START_ADDRESS (START_ADDRESS)
    ) u_issue_stage (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable_i),
        .flush_i      (flush),
        .head_entry_i (head_entry),
        .not_empty_i  (not_empty),
        .pop_o        (pop),
        .issue_o      (issue_o),
        .valid_o      (valid_o),
        .jumping_o    (jumping_o)
    );

endmodule

//--- design/instr_queue.sv
// Caller must never push into a full queue; IQUEUE_SIZE of at least 2, not only powers of two
`timescale 1ns/1ps

module instr_queue #(
    parameter int IQUEUE_SIZE = 2
) (
    input  logic                               clk,
    input  logic                               reset_n,

    input  logic                               flush_i,

    // Write side
    input  logic                               push_i,
    input  fetch_pkg::fetch_entry_t            push_entry_i,

    // Read side
    input  logic                               pop_i,
    output fetch_pkg::fetch_entry_t            head_entry_o,
    output logic                               not_empty_o,
    output logic [$clog2(IQUEUE_SIZE+1)-1:0]   count_o
);

    localparam int CNT_W = $clog2(IQUEUE_SIZE + 1);
    localparam int PTR_W = $clog2(IQUEUE_SIZE);

    // Last valid slot index, for pointer wrap
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(IQUEUE_SIZE - 1);

    fetch_pkg::fetch_entry_t storage_q [IQUEUE_SIZE];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Flush beats a push at the same edge
    assign do_push = push_i & ~flush_i;
    // Nothing to pop from an empty queue
    assign do_pop  = pop_i & not_empty_o;

    // Entry storage written at the write pointer
    always_ff @(posedge clk) begin
        if (do_push) begin
            storage_q[wr_ptr_q] <= push_entry_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head read straight from storage
    assign head_entry_o = storage_q[rd_ptr_q];
    assign not_empty_o  = count_q != '0;

    // Entries still held after this edge's pop
    // Lets the requester reuse a slot freed in the same cycle
    assign count_o = count_q - CNT_W'(do_pop);

endmodule

//--- design/issue_stage.sv
// Output holds while enable_i is low; issued pc comes only from the queue entry
`timescale 1ns/1ps

module issue_stage #(
    parameter fetch_pkg::addr_t START_ADDRESS = 32'h0000_0000
) (
    input  logic                    clk,
    input  logic                    reset_n,

    // Decode back-pressure
    input  logic                    enable_i,

    input  logic                    flush_i,

    // Queue head
    input  fetch_pkg::fetch_entry_t head_entry_i,
    input  logic                    not_empty_i,
    output logic                    pop_o,

    // Toward decode
    output fetch_pkg::issue_t       issue_o,
    output logic                    valid_o,
    output logic                    jumping_o
);

    logic load;

    // Slot is free, or its content is taken by decode this edge
    assign load  = not_empty_i & (enable_i | ~valid_o);
    assign pop_o = load;

    // Output register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_o.pc    <= START_ADDRESS;
            issue_o.instr <= fetch_pkg::NOP_INSTR;
        end else if (load && !flush_i) begin
            issue_o.pc    <= head_entry_i.pc;
            issue_o.instr <= head_entry_i.instr;
        end
    end

    // Valid and jumping flags
    // Jumping stays up from redirect to first new valid
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o   <= 1'b0;
            jumping_o <= 1'b1;
        end else if (flush_i) begin
            valid_o   <= 1'b0;
            jumping_o <= 1'b1;
        end else if (load) begin
            valid_o   <= 1'b1;
            jumping_o <= 1'b0;
        end else if (enable_i) begin
            // Consumed with nothing to replace it
            valid_o   <= 1'b0;
        end
    end

endmodule

//--- flist.f
design/fetch_pkg.sv
design/fetch_request.sv
design/instr_queue.sv
design/issue_stage.sv
design/fetch_unit.sv
tests/tb_clock_gen.sv
tests/fetch_unit_assert.sv
tests/fetch_unit_tb.sv

//--- tests/fetch_unit_assert.sv
// Bound into every fetch_unit instance; checks sampled on the rising edge outside reset only
`timescale 1ns/1ps

module fetch_unit_assert (
    input logic                 clk,
    input logic                 reset_n,
    input logic                 enable_i,
    input fetch_pkg::jump_req_t jump_i,
    input fetch_pkg::mem_req_t  mem_req_o,
    input fetch_pkg::issue_t    issue_o,
    input logic                 valid_o,
    input logic                 jumping_o
);

    // Fetch address always on a word boundary
    a_addr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        mem_req_o.addr[1:0] == 2'b00)
        else $error("fetch address not word-aligned");

    // Redirect empties the issue slot at once
    a_invalid_after_jump: assert property (@(posedge clk) disable iff (!reset_n)
        (jump_i.jump || jump_i.ctx_switch) |=> !valid_o)
        else $error("valid_o high in the cycle after a redirect");

    // Back-pressure holds the issued instruction
    a_hold_issue: assert property (@(posedge clk) disable iff (!reset_n)
        (valid_o && !enable_i) |=> $stable(issue_o))
        else $error("issue_o changed while stalled by decode");

    // Flags exclusive
    a_flags_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(valid_o && jumping_o))
        else $error("jumping_o and valid_o high together");

endmodule

bind fetch_unit fetch_unit_assert u_fetch_unit_assert (
    .clk       (clk),
    .reset_n   (reset_n),
    .enable_i  (enable_i),
    .jump_i    (jump_i),
    .mem_req_o (mem_req_o),
    .issue_o   (issue_o),
    .valid_o   (valid_o),
    .jumping_o (jumping_o)
);

//--- tests/fetch_unit_tb.sv
// Memory answers in the next cycle with the inverted address; table targets must be word-aligned
`timescale 1ns/1ps

module fetch_unit_tb;

    localparam fetch_pkg::addr_t START_ADDRESS = 32'h0000_1000;
    localparam int IQUEUE_SIZE = 2;
    localparam int ISSUE_TIMEOUT = 64;
    localparam int N_ROWS = 5;
    // Redirect kinds with bit 0 for jump and bit 1 for context switch
    localparam logic [1:0] RD_NONE = 2'b00;
    localparam logic [1:0] RD_JUMP = 2'b01;
    localparam logic [1:0] RD_CTX  = 2'b10;
    localparam logic [1:0] RD_BOTH = 2'b11;

    typedef struct packed {
        int               busy_pct;
        int               en_pct;
        int               n_issues;
        logic [1:0]       kind;
        fetch_pkg::addr_t jump_target;
        fetch_pkg::addr_t ctx_target;
        fetch_pkg::addr_t exp_start;
    } row_t;

    logic clk;
    logic reset_n;
    logic enable_i;
    logic busy_i;
    fetch_pkg::jump_req_t jump_i;
    fetch_pkg::instr_t    mem_data_i;
    fetch_pkg::mem_req_t  mem_req_o;
    fetch_pkg::issue_t    issue_o;
    logic valid_o;
    logic jumping_o;

    row_t  rows [N_ROWS];
    string row_names [N_ROWS];
    string cur_name = "reset";
    int busy_pct = 0;
    int en_pct = 0;
    int n_checks = 0;
    int n_errors = 0;
    int n_timeouts = 0;
    int consumed = 0;
    logic [31:0] rng_state = 32'd22;
    fetch_pkg::addr_t resp_addr = '0;
    fetch_pkg::addr_t exp_pc = START_ADDRESS;
    fetch_pkg::addr_t cur_exp_start = START_ADDRESS;
    fetch_pkg::issue_t last_issue = '0;
    logic pend_jump = 1'b1;
    logic after_jump = 1'b0;
    logic last_valid = 1'b0;
    logic last_enable = 1'b0;
    bit ok;

    tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(2)) u_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    fetch_unit #(.START_ADDRESS(START_ADDRESS), .IQUEUE_SIZE(IQUEUE_SIZE)) u_fetch_unit (
        .clk        (clk),
        .reset_n    (reset_n),
        .enable_i   (enable_i),
        .issue_o    (issue_o),
        .valid_o    (valid_o),
        .jumping_o  (jumping_o),
        .jump_i     (jump_i),
        .busy_i     (busy_i),
        .mem_data_i (mem_data_i),
        .mem_req_o  (mem_req_o)
    );

    // LCG with the percent taken from the upper state bits
    function automatic int lcg_percent();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[30:16]) % 100;
    endfunction

    task automatic check_issue(input string name, input fetch_pkg::issue_t actual,
                               input fetch_pkg::issue_t expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s: expected pc=%h instr=%h, actual pc=%h instr=%h",
                     name, expected.pc, expected.instr, actual.pc, actual.instr);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // One falling edge of random stall and back-pressure
    task automatic drive_random();
        @(negedge clk);
        busy_i   = lcg_percent() < busy_pct;
        enable_i = lcg_percent() < en_pct;
    endtask

    // Idle counter restarts on each consumed issue
    task automatic wait_issues(input int target, output bit done);
        int idle;
        int seen;
        idle = 0;
        seen = consumed;
        while (consumed < target && idle < ISSUE_TIMEOUT) begin
            drive_random();
            if (consumed != seen) begin
                seen = consumed;
                idle = 0;
            end else begin
                idle++;
            end
        end
        done = consumed >= target;
        if (!done) begin
            n_timeouts++;
            $display("ERROR: no issue within timeout in row %s", cur_name);
        end
    endtask

    // Strobe lasts one cycle
    task automatic apply_redirect(input row_t row);
        cur_exp_start      = row.exp_start;
        jump_i.jump        = row.kind[0];
        jump_i.ctx_switch  = row.kind[1];
        jump_i.jump_target = row.jump_target;
        jump_i.ctx_target  = row.ctx_target;
        drive_random();
        jump_i = '0;
    endtask

    // Memory model registers the accepted address and answers at the falling edge
    always @(posedge clk) begin
        if (mem_req_o.en && !busy_i) begin
            resp_addr <= mem_req_o.addr;
        end
    end

    always @(negedge clk) begin
        mem_data_i <= ~resp_addr;
    end

    // Monitor of consumed issues and flags
    always @(posedge clk) begin
        fetch_pkg::issue_t exp_issue;
        logic redirect;
        if (reset_n) begin
            redirect = jump_i.jump | jump_i.ctx_switch;
            check_flag("flags_exclusive", valid_o & jumping_o, 1'b0);
            check_flag("jumping", jumping_o, pend_jump & ~valid_o);
            if (after_jump) begin
                check_flag("valid_after_jump", valid_o, 1'b0);
            end
            if (last_valid && !last_enable) begin
                check_issue("hold_under_backpressure", issue_o, last_issue);
            end
            // Issue at the redirect edge still belongs to the old stream
            if (valid_o && enable_i) begin
                exp_issue.pc    = exp_pc;
                exp_issue.instr = ~exp_pc;
                check_issue(cur_name, issue_o, exp_issue);
                exp_pc = exp_pc + fetch_pkg::PC_STEP;
                consumed++;
            end
            if (valid_o) begin
                pend_jump = 1'b0;
            end
            if (redirect) begin
                exp_pc    = cur_exp_start;
                pend_jump = 1'b1;
            end
            after_jump  = redirect;
            last_valid  = valid_o;
            last_enable = enable_i;
            last_issue  = issue_o;
        end
    end

    initial begin
        fetch_pkg::issue_t reset_issue;
        busy_i     = 1'b0;
        enable_i   = 1'b0;
        jump_i     = '0;
        mem_data_i = '0;
        // busy, enable, issues, kind, jump target, ctx target, expected start
        rows[0] = '{0, 100, 8, RD_JUMP, 32'h0000_2000, 32'h0, 32'h0000_2000};
        rows[1] = '{40, 60, 20, RD_CTX, 32'h0000_3000, 32'h0000_4000, 32'h0000_4000};
        rows[2] = '{0, 100, 6, RD_BOTH, 32'h0000_5000, 32'h0000_6000, 32'h0000_6000};
        rows[3] = '{50, 50, 25, RD_JUMP, 32'h0000_7100, 32'h0000_8000, 32'h0000_7100};
        rows[4] = '{20, 80, 12, RD_NONE, 32'h0, 32'h0, 32'h0};
        row_names = '{"sequential", "stall_ctx", "both_strobes", "random_jump", "tail"};

        // Reset state sampled while reset is still low
        @(negedge clk);
        reset_issue.pc    = START_ADDRESS;
        reset_issue.instr = fetch_pkg::NOP_INSTR;
        check_flag("reset_valid", valid_o, 1'b0);
        check_flag("reset_jumping", jumping_o, 1'b1);
        check_flag("reset_mem_en", mem_req_o.en, 1'b0);
        check_issue("reset_issue", issue_o, reset_issue);

        // Reset release seen at a rising edge
        ok = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (reset_n) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            n_timeouts++;
            $display("ERROR: reset was never released");
        end

        for (int r = 0; r < N_ROWS && ok; r++) begin
            cur_name = row_names[r];
            busy_pct = rows[r].busy_pct;
            en_pct   = rows[r].en_pct;
            wait_issues(consumed + rows[r].n_issues, ok);
            if (ok && rows[r].kind != RD_NONE) begin
                apply_redirect(rows[r]);
            end
        end

        $display("Checks: %0d, value errors: %0d, timeouts: %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
// Clock runs from time zero; reset_n rises on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_n_o
);

    // Clock starts low with the first rising edge after half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

    // Reset held low over the first rising edges
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o = 1'b1;
    end

endmodule
